//--- sim.f
+incdir+.
muldiv_pkg.sv
int_divider.sv
int_multiplier.sv
muldiv_unit.sv
tb_muldiv.sv

//--- Bender.yml
package:
  name: muldiv

sources:
  - muldiv_pkg.sv
  - int_divider.sv
  - int_multiplier.sv
  - muldiv_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_muldiv.sv

//--- muldiv_ref_model.svh
`ifndef MULDIV_REF_MODEL_SVH
`define MULDIV_REF_MODEL_SVH

// true for the four operations that go to the divider
function automatic logic is_divide(input muldiv_pkg::muldiv_op_e op);
  return op[2];
endfunction

// expected result of one M-extension operation, straight from the ISA rules
function automatic logic [31:0] expected_result(input muldiv_pkg::muldiv_op_e op,
                                                input logic [31:0] a,
                                                input logic [31:0] b);
  logic [63:0] prod;
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic signed [63:0] ub;
  logic signed [31:0] sa32;
  logic signed [31:0] sb32;
  logic ovf;
  sa = {{32{a[31]}}, a};
  sb = {{32{b[31]}}, b};
  ub = {32'b0, b};
  sa32 = a;
  sb32 = b;
  ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  case (op)
    muldiv_pkg::op_mul: begin
      prod = {32'b0, a} * {32'b0, b};
      return prod[31:0];
    end
    muldiv_pkg::op_mulh: begin
      prod = sa * sb;
      return prod[63:32];
    end
    muldiv_pkg::op_mulhsu: begin
      prod = sa * ub;
      return prod[63:32];
    end
    muldiv_pkg::op_mulhu: begin
      prod = {32'b0, a} * {32'b0, b};
      return prod[63:32];
    end
    // signed division truncates toward zero, the remainder keeps the dividend sign
    muldiv_pkg::op_div: begin
      if (b == 0) return 32'hffff_ffff;
      if (ovf) return 32'h8000_0000;
      return sa32 / sb32;
    end
    muldiv_pkg::op_rem: begin
      if (b == 0) return a;
      if (ovf) return 32'h0;
      return sa32 % sb32;
    end
    muldiv_pkg::op_divu: begin
      if (b == 0) return 32'hffff_ffff;
      return a / b;
    end
    default: begin
      if (b == 0) return a;
      return a % b;
    end
  endcase
endfunction

`endif

//--- tb_muldiv.sv
`timescale 1ns/10ps
`default_nettype none

module tb_muldiv;

  `include "muldiv_ref_model.svh"

  localparam int n_mul = 200;
  localparam int n_div = 200;
  localparam int n_zero = 8;
  localparam int n_ovf = 4;
  localparam int n_mix = 300;
  localparam int n_lz = 150;
  localparam int total_ops = n_mul + n_div + n_zero + n_ovf + n_mix + n_lz;

  logic clk;
  logic rst;
  logic in_valid;
  muldiv_pkg::muldiv_op_e in_op;
  logic [31:0] in_a;
  logic [31:0] in_b;
  logic in_ready;
  logic out_valid;
  logic [31:0] out_result;
  logic out_ready;

  logic [31:0] exp_q[$];
  logic div_q[$];
  int start_q[$];
  int cycle;
  int checks;
  int errors;
  int checks_at_start;
  int errors_at_start;
  logic ready_random;
  logic lat_check;
  logic hold_pending;
  logic [31:0] held;

  muldiv_unit DUT (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_ready  (out_ready)
  );

  always #10 clk = ~clk;

  // result consumer with optional random backpressure
  always @(posedge clk) begin
    #1;
    if (ready_random) begin
      out_ready = ($urandom_range(1, 0) == 1);
    end else begin
      out_ready = 1'b1;
    end
  end

  // monitor runs on the falling edge while inputs and outputs are settled
  always @(negedge clk) begin
    logic [31:0] want;
    logic was_div;
    int t0;
    logic ready_exp;
    logic ready_known;
    if (rst) begin
      // in_ready follows from the operations still outstanding
      ready_known = 1'b1;
      if (exp_q.size() == 0) begin
        ready_exp = 1'b1;
      end else if (div_q[0] || is_divide(in_op)) begin
        ready_exp = 1'b0;
      end else begin
        ready_exp = 1'b0;
        ready_known = 1'b0;
      end
      if (ready_known) begin
        assert (in_ready === ready_exp) else begin
          errors++;
          $display("mismatch in_ready: expected %0h actual %0h", ready_exp, in_ready);
        end
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(expected_result(in_op, in_a, in_b));
        div_q.push_back(is_divide(in_op));
        start_q.push_back(cycle);
      end
      if (hold_pending) begin
        assert (out_valid) else begin
          errors++;
          $display("out_valid dropped before the waiting result was taken");
        end
        assert (out_result === held) else begin
          errors++;
          $display("mismatch out_result while waiting: expected %08h actual %08h",
                   held, out_result);
        end
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("a result came out with no operation outstanding");
        end else begin
          want = exp_q.pop_front();
          was_div = div_q.pop_front();
          t0 = start_q.pop_front();
          checks++;
          assert (out_result === want) else begin
            errors++;
            $display("mismatch out_result: expected %08h actual %08h", want, out_result);
          end
          if (was_div && lat_check) begin
            assert (cycle - t0 <= 35) else begin
              errors++;
              $display("a divide took %0d cycles from acceptance to its result", cycle - t0);
            end
          end
        end
      end
      hold_pending = out_valid && !out_ready;
      held = out_result;
    end
    cycle++;
  end

  initial begin
    #(longint'(total_ops) * 40 * 20 * 2);
    $display("the run did not finish in time, results are missing or the DUT is stuck");
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic send(input muldiv_pkg::muldiv_op_e op, input logic [31:0] a,
                      input logic [31:0] b);
    logic taken;
    in_valid = 1'b1;
    in_op = op;
    in_a = a;
    in_b = b;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic idle_cycle();
    in_valid = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic drain();
    in_valid = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0);
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s finished: %0d results checked, %0d errors", num, name,
             checks - checks_at_start, errors - errors_at_start);
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  function automatic logic [31:0] random_divisor();
    logic [31:0] d;
    int sh;
    d = $urandom;
    sh = $urandom_range(31, 0);
    d = d >> sh;
    if (d == 0) d = 1;
    if ($urandom_range(1, 0) == 1) d = -d;
    return d;
  endfunction

  initial begin
    muldiv_pkg::muldiv_op_e op;
    logic [31:0] a;
    logic [31:0] b;
    int sh;
    void'($urandom(32'h52f8_017a));
    clk = 1'b0;
    rst = 1'b0;
    in_valid = 1'b0;
    in_op = muldiv_pkg::op_mul;
    in_a = '0;
    in_b = '0;
    out_ready = 1'b1;
    ready_random = 1'b0;
    lat_check = 1'b1;
    hold_pending = 1'b0;
    held = '0;
    cycle = 0;
    checks = 0;
    errors = 0;
    checks_at_start = 0;
    errors_at_start = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b1;
    @(posedge clk);
    #1;

    repeat (n_mul) begin
      op = muldiv_pkg::muldiv_op_e'($urandom_range(3, 0));
      a = $urandom;
      b = $urandom;
      send(op, a, b);
    end
    drain();
    report_test(1, "random multiplies");

    repeat (n_div) begin
      op = muldiv_pkg::muldiv_op_e'($urandom_range(7, 4));
      a = $urandom;
      b = random_divisor();
      send(op, a, b);
    end
    drain();
    report_test(2, "random divides");

    for (int i = 0; i < n_zero; i++) begin
      a = (i == 0) ? 32'h8000_0000 : $urandom;
      send(muldiv_pkg::muldiv_op_e'(4 + (i % 4)), a, 32'h0);
    end
    drain();
    report_test(3, "zero divisor");

    for (int i = 0; i < n_ovf; i++) begin
      send(muldiv_pkg::muldiv_op_e'(4 + i), 32'h8000_0000, 32'hffff_ffff);
    end
    drain();
    report_test(4, "signed overflow");

    lat_check = 1'b0;
    ready_random = 1'b1;
    repeat (n_mix) begin
      op = muldiv_pkg::muldiv_op_e'($urandom_range(7, 0));
      a = $urandom;
      b = ($urandom_range(15, 0) == 0) ? 32'h0 : random_divisor();
      send(op, a, b);
      if ($urandom_range(3, 0) == 0) idle_cycle();
    end
    drain();
    ready_random = 1'b0;
    idle_cycle();
    idle_cycle();
    lat_check = 1'b1;
    report_test(5, "random backpressure");

    repeat (n_lz) begin
      op = muldiv_pkg::muldiv_op_e'($urandom_range(7, 4));
      a = $urandom;
      sh = $urandom_range(32, 0);
      // a quarter keep the full width
      if ($urandom_range(3, 0) != 0) begin
        a = (sh == 32) ? 32'h0 : (a >> sh);
      end
      b = random_divisor();
      send(op, a, b);
    end
    drain();
    report_test(6, "small dividends");

    $display("summary: %0d results checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- muldiv_unit.sv
`timescale 1ns/10ps
`default_nettype none

module muldiv_unit (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   in_valid,
  input  wire muldiv_pkg::muldiv_op_e in_op,
  input  wire logic [31:0]            in_a,
  input  wire logic [31:0]            in_b,
  output logic                        in_ready,
  output logic                        out_valid,
  output logic [31:0]                 out_result,
  input  wire logic                   out_ready
);

  logic is_div;
  logic mul_free;
  logic accept;

  logic div_start;
  logic div_busy;
  logic div_res_valid;
  logic [muldiv_pkg::xlen-1:0] div_res;
  logic div_res_ready;

  logic mul_start;
  logic mul_busy;
  logic mul_res_valid;
  logic [muldiv_pkg::xlen-1:0] mul_res;
  logic mul_res_ready;

  assign is_div = (in_op == muldiv_pkg::op_div) || (in_op == muldiv_pkg::op_divu) ||
                  (in_op == muldiv_pkg::op_rem) || (in_op == muldiv_pkg::op_remu);

  // multiplier takes a new item unless its output is stalled
  assign mul_free = !mul_res_valid || out_ready;

  // a divide waits for the multiplier to drain so results stay in order
  assign in_ready = !div_busy && (is_div ? !mul_busy : mul_free);
  assign accept = in_valid && in_ready;

  assign div_start = accept && is_div;
  assign mul_start = accept && !is_div;

  int_divider u_divider (
    .clk       (clk),
    .rst       (rst),
    .start     (div_start),
    .op        (in_op),
    .a         (in_a),
    .b         (in_b),
    .res_ready (div_res_ready),
    .busy      (div_busy),
    .res_valid (div_res_valid),
    .res       (div_res)
  );

  int_multiplier u_multiplier (
    .clk       (clk),
    .rst       (rst),
    .start     (mul_start),
    .op        (in_op),
    .a         (in_a),
    .b         (in_b),
    .res_ready (mul_res_ready),
    .busy      (mul_busy),
    .res_valid (mul_res_valid),
    .res       (mul_res)
  );

  // only one unit holds a result at any time
  assign out_valid = div_res_valid || mul_res_valid;
  assign out_result = div_res_valid ? div_res : mul_res;

  assign div_res_ready = out_ready && div_res_valid;
  assign mul_res_ready = out_ready && mul_res_valid;

  a_one_result: assert property (
    @(posedge clk) disable iff (!rst)
    !(div_res_valid && mul_res_valid)
  );

endmodule

`default_nettype wire

//--- int_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module int_multiplier (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   start,
  input  wire muldiv_pkg::muldiv_op_e op,
  input  wire logic [31:0]            a,
  input  wire logic [31:0]            b,
  input  wire logic                   res_ready,
  output logic                        busy,
  output logic                        res_valid,
  output logic [31:0]                 res
);

  // operand extension
  logic a_signed;
  logic b_signed;
  logic signed [muldiv_pkg::xlen:0] a_ext;
  logic signed [muldiv_pkg::xlen:0] b_ext;
  logic sel_high;

  // stage 1 holds the extended operands
  logic s1_valid;
  logic signed [muldiv_pkg::xlen:0] s1_a;
  logic signed [muldiv_pkg::xlen:0] s1_b;
  logic s1_high;

  // stage 2 holds the full product
  logic s2_valid;
  logic signed [2*muldiv_pkg::xlen+1:0] s2_prod;
  logic s2_high;

  logic advance;

  always_comb begin
    a_signed = (op == muldiv_pkg::op_mulh) || (op == muldiv_pkg::op_mulhsu);
    b_signed = (op == muldiv_pkg::op_mulh);
    a_ext = {a_signed && a[muldiv_pkg::xlen-1], a};
    b_ext = {b_signed && b[muldiv_pkg::xlen-1], b};
    // mul keeps the low word, the rest return the high word
    sel_high = (op != muldiv_pkg::op_mul);
  end

  // whole pipe freezes while a finished product waits
  assign advance = !s2_valid || res_ready;

  always_ff @(posedge clk) begin
    if (!rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= start;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && start) begin
      s1_a <= a_ext;
      s1_b <= b_ext;
      s1_high <= sel_high;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && s1_valid) begin
      s2_prod <= s1_a * s1_b;
      s2_high <= s1_high;
    end
  end

  assign res = s2_high ? s2_prod[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen]
                       : s2_prod[muldiv_pkg::xlen-1:0];
  assign res_valid = s2_valid;
  assign busy = s1_valid || s2_valid;

  // the dispatcher must hold off new multiplies during a stall
  a_no_start_stall: assert property (
    @(posedge clk) disable iff (!rst)
    start |-> advance
  );

endmodule

`default_nettype wire

//--- int_divider.sv
`timescale 1ns/10ps
`default_nettype none

module int_divider (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   start,
  input  wire muldiv_pkg::muldiv_op_e op,
  input  wire logic [31:0]            a,
  input  wire logic [31:0]            b,
  input  wire logic                   res_ready,
  output logic                        busy,
  output logic                        res_valid,
  output logic [31:0]                 res
);

  muldiv_pkg::div_state_e state;
  logic [muldiv_pkg::div_count_w-1:0] count;

  // operation record captured at start
  muldiv_pkg::muldiv_op_e op_q;
  logic [muldiv_pkg::xlen-1:0] a_q;
  logic [muldiv_pkg::xlen-1:0] divisor;
  logic neg_q;
  logic neg_r;
  logic div_zero;
  logic overflow;

  // remainder in the upper half, quotient in the lower half
  logic [2*muldiv_pkg::xlen:0] rq;

  // operand preparation
  logic op_signed;
  logic a_neg;
  logic b_neg;
  logic [muldiv_pkg::xlen-1:0] a_abs;
  logic [muldiv_pkg::xlen-1:0] b_abs;
  logic [muldiv_pkg::div_count_w-1:0] lz;
  logic start_zero;
  logic start_ovf;

  // one restoring step
  logic [2*muldiv_pkg::xlen:0] shifted;
  logic [muldiv_pkg::xlen:0] diff;

  logic is_rem;

  always_comb begin
    op_signed = (op == muldiv_pkg::op_div) || (op == muldiv_pkg::op_rem);
    a_neg = op_signed && a[muldiv_pkg::xlen-1];
    b_neg = op_signed && b[muldiv_pkg::xlen-1];
    a_abs = a_neg ? -a : a;
    b_abs = b_neg ? -b : b;
    start_zero = (b == '0);
    start_ovf = op_signed && (a == 32'h8000_0000) && (b == '1);
  end

  // leading zeros of the magnitude, the highest set bit wins
  always_comb begin
    lz = muldiv_pkg::div_count_w'(muldiv_pkg::xlen);
    for (int i = 0; i < muldiv_pkg::xlen; i++) begin
      if (a_abs[i]) begin
        lz = muldiv_pkg::div_count_w'(muldiv_pkg::xlen - 1 - i);
      end
    end
  end

  always_comb begin
    shifted = {rq[2*muldiv_pkg::xlen-1:0], 1'b0};
    diff = shifted[2*muldiv_pkg::xlen:muldiv_pkg::xlen] - {1'b0, divisor};
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= muldiv_pkg::div_idle;
      count <= '0;
    end else begin
      case (state)
        muldiv_pkg::div_idle: begin
          if (start) begin
            // corner cases and a zero dividend need no iterations
            if (start_zero || start_ovf || (lz == muldiv_pkg::div_count_w'(muldiv_pkg::xlen))) begin
              state <= muldiv_pkg::div_fix;
            end else begin
              state <= muldiv_pkg::div_iterate;
            end
            count <= muldiv_pkg::div_count_w'(muldiv_pkg::xlen) - lz;
          end
        end
        muldiv_pkg::div_iterate: begin
          count <= count - 1'b1;
          if (count == 1) begin
            state <= muldiv_pkg::div_fix;
          end
        end
        muldiv_pkg::div_fix: begin
          state <= muldiv_pkg::div_done;
        end
        muldiv_pkg::div_done: begin
          if (res_ready) begin
            state <= muldiv_pkg::div_idle;
          end
        end
        default: begin
          state <= muldiv_pkg::div_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      muldiv_pkg::div_idle: begin
        if (start) begin
          op_q <= op;
          a_q <= a;
          divisor <= b_abs;
          neg_q <= a_neg ^ b_neg;
          neg_r <= a_neg;
          div_zero <= start_zero;
          overflow <= start_ovf;
          // skipped leading zeros would only have shifted in zero quotient bits
          rq <= {{(muldiv_pkg::xlen+1){1'b0}}, a_abs} << lz;
        end
      end
      muldiv_pkg::div_iterate: begin
        if (!diff[muldiv_pkg::xlen]) begin
          rq <= {diff, shifted[muldiv_pkg::xlen-1:1], 1'b1};
        end else begin
          rq <= shifted;
        end
      end
      muldiv_pkg::div_fix: begin
        if (neg_q) begin
          rq[muldiv_pkg::xlen-1:0] <= -rq[muldiv_pkg::xlen-1:0];
        end
        // remainder follows the sign of the dividend
        if (neg_r) begin
          rq[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen] <=
            -rq[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];
        end
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    is_rem = (op_q == muldiv_pkg::op_rem) || (op_q == muldiv_pkg::op_remu);
    if (div_zero) begin
      res = is_rem ? a_q : '1;
    end else if (overflow) begin
      res = is_rem ? '0 : 32'h8000_0000;
    end else if (is_rem) begin
      res = rq[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];
    end else begin
      res = rq[muldiv_pkg::xlen-1:0];
    end
  end

  assign busy = (state != muldiv_pkg::div_idle);
  assign res_valid = (state == muldiv_pkg::div_done);

  a_res_hold: assert property (
    @(posedge clk) disable iff (!rst)
    res_valid && !res_ready |=> res_valid && $stable(res)
  );

  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!rst)
    start |-> !busy
  );

endmodule

`default_nettype wire

//--- muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

  // operand and result width of the integer core
  localparam int xlen = 32;

  // iteration counter of the divider, holds 0 to xlen
  localparam int div_count_w = 6;

  // M-extension operations, encoded as funct3
  typedef enum logic [2:0] {
    op_mul    = 3'b000,
    op_mulh   = 3'b001,
    op_mulhsu = 3'b010,
    op_mulhu  = 3'b011,
    op_div    = 3'b100,
    op_divu   = 3'b101,
    op_rem    = 3'b110,
    op_remu   = 3'b111
  } muldiv_op_e;

  // divider sequencing
  // idle waits for start
  // iterate runs one quotient bit per cycle
  // fix applies the result signs
  // done holds the result until it is taken
  typedef enum logic [1:0] {
    div_idle    = 2'b00,
    div_iterate = 2'b01,
    div_fix     = 2'b10,
    div_done    = 2'b11
  } div_state_e;

endpackage

`default_nettype wire
